/* design/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address and data width, rv32 throughout
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// memory depth in 32-bit words
`define MEM_WORDS 256

// cycles from accepted ar to r valid, any value >= 1
`define MEM_LATENCY 3

// opcodes seen by the static predictor
`define OPC_JAL 7'b1101111
`define OPC_BRANCH 7'b1100011

`endif

/* design/fetch_pkg.sv */
package fetch_pkg;

  // j-format view, immediate bits scattered over the upper word
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_jtype_t;

  // b-format view
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_btype_t;

  // one fetched word, decoded as jal and as branch at once
  typedef union packed {
    rv_jtype_t   j;
    rv_btype_t   b;
    logic [31:0] raw;
  } inst_u;

  // read response code
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

/* design/axi_rd_if.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

interface axi_rd_if import fetch_pkg::*; ();
  // read address channel
  logic             ar_valid;
  logic             ar_ready;
  logic [`XLEN-1:0] ar_addr;

  // read data channel
  logic             r_valid;
  logic             r_ready;
  logic [`XLEN-1:0] r_data;
  axi_resp_e        r_resp;

  // requester side
  modport master (
    output ar_valid, ar_addr, r_ready,
    input  ar_ready, r_valid, r_data, r_resp
  );

  // responder side
  modport slave (
    input  ar_valid, ar_addr, r_ready,
    output ar_ready, r_valid, r_data, r_resp
  );

endinterface

/* design/pc_predict.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module pc_predict import fetch_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_i,
  input  logic [`XLEN-1:0] redirect_pc_i,
  input  logic             stall_i,
  input  logic             rsp_strobe_i,
  input  inst_u            rsp_inst_i,
  output logic [`XLEN-1:0] fetch_pc_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] j_off;
  logic [`XLEN-1:0] b_off;
  logic [`XLEN-1:0] next_pc;

  // sign-extended jal offset, bit 0 always zero
  assign j_off = {{12{rsp_inst_i.j.imm20}}, rsp_inst_i.j.imm19_12,
                  rsp_inst_i.j.imm11, rsp_inst_i.j.imm10_1, 1'b0};

  // sign-extended branch offset
  assign b_off = {{20{rsp_inst_i.b.imm12}}, rsp_inst_i.b.imm11,
                  rsp_inst_i.b.imm10_5, rsp_inst_i.b.imm4_1, 1'b0};

  // static prediction on the word just delivered
  always_comb begin
    if (rsp_inst_i.j.opcode == `OPC_JAL) begin
      // jal always taken
      next_pc = pc_q + j_off;
    end else if (rsp_inst_i.b.opcode == `OPC_BRANCH && rsp_inst_i.b.imm12) begin
      // backward branch predicted taken
      next_pc = pc_q + b_off;
    end else begin
      next_pc = pc_q + `XLEN'd4;
    end
  end

  // redirect beats prediction, stall freezes the pc
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (rsp_strobe_i && !stall_i) begin
      pc_q <= next_pc;
    end
  end

  assign fetch_pc_o = pc_q;

  // redirect targets and predicted targets must keep word alignment
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_pc_o[1:0] == 2'b00);

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit import fetch_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [`XLEN-1:0] fetch_pc_i,
  input  logic             redirect_i,
  input  logic             stall_i,
  axi_rd_if.master         bus,
  output logic             inst_valid_o,
  output logic [31:0]      inst_o,
  output logic [`XLEN-1:0] inst_pc_o,
  output logic             rsp_strobe_o,
  output inst_u            rsp_inst_o
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_ADDR = 2'd1;
  localparam logic [1:0] S_WAIT = 2'd2;
  localparam logic [1:0] S_HOLD = 2'd3;

  logic [1:0]       state_q;
  logic [1:0]       state_d;
  logic             stale_q;
  logic             addr_held_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] pc_q;
  inst_u            inst_q;
  logic             ar_fire;
  logic             r_fire;
  logic             drop;
  logic             consume;

  // first address cycle takes the live pc, later cycles the held copy
  assign bus.ar_valid = (state_q == S_ADDR);
  assign bus.ar_addr  = addr_held_q ? addr_q : fetch_pc_i;
  assign bus.r_ready  = (state_q == S_WAIT);

  assign ar_fire = bus.ar_valid & bus.ar_ready;
  assign r_fire  = bus.r_valid & bus.r_ready;
  // response of a redirected read is thrown away
  assign drop    = stale_q | redirect_i;
  assign consume = (state_q == S_HOLD) & ~stall_i & ~redirect_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (!redirect_i) begin
          state_d = S_ADDR;
        end
      end
      S_ADDR: begin
        if (ar_fire) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (r_fire && !drop) begin
          state_d = S_HOLD;
        end else if (r_fire) begin
          // pc already moved, refetch unless redirect still up
          state_d = redirect_i ? S_IDLE : S_ADDR;
        end
      end
      default: begin
        if (redirect_i) begin
          state_d = S_IDLE;
        end else if (consume) begin
          state_d = S_ADDR;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= S_IDLE;
      stale_q     <= 1'b0;
      addr_held_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      addr_held_q <= bus.ar_valid & ~bus.ar_ready;
      if (r_fire) begin
        stale_q <= 1'b0;
      end else if (redirect_i && (state_q == S_ADDR || state_q == S_WAIT)) begin
        stale_q <= 1'b1;
      end
    end
  end

  // address, pc and instruction payload
  always_ff @(posedge clk) begin
    if (bus.ar_valid) begin
      addr_q <= bus.ar_addr;
    end
    if (ar_fire) begin
      pc_q <= bus.ar_addr;
    end
    if (r_fire && !drop) begin
      inst_q <= bus.r_data;
    end
  end

  assign inst_valid_o = (state_q == S_HOLD);
  assign inst_o       = inst_q.raw;
  assign inst_pc_o    = pc_q;
  assign rsp_strobe_o = consume;
  assign rsp_inst_o   = inst_q;

  // pending request keeps its address through arbiter and slave backpressure
  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    bus.ar_valid && !bus.ar_ready |=> bus.ar_valid && $stable(bus.ar_addr));

endmodule

/* design/load_port.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module load_port import fetch_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ld_req_i,
  input  logic [`XLEN-1:0] ld_addr_i,
  axi_rd_if.master         bus,
  output logic             ld_done_o,
  output logic [`XLEN-1:0] ld_data_o,
  output logic             ld_busy_o
);

  localparam logic [1:0] L_IDLE = 2'd0;
  localparam logic [1:0] L_ADDR = 2'd1;
  localparam logic [1:0] L_WAIT = 2'd2;

  logic [1:0]       state_q;
  logic             done_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] data_q;

  assign bus.ar_valid = (state_q == L_ADDR);
  assign bus.ar_addr  = addr_q;
  assign bus.r_ready  = (state_q == L_WAIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= L_IDLE;
      done_q  <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done_q <= 1'b0;
      case (state_q)
        L_IDLE: begin
          if (ld_req_i) begin
            state_q <= L_ADDR;
          end
        end
        L_ADDR: begin
          if (bus.ar_ready) begin
            state_q <= L_WAIT;
          end
        end
        default: begin
          if (bus.r_valid) begin
            state_q <= L_IDLE;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // request while busy is ignored
    if (state_q == L_IDLE && ld_req_i) begin
      addr_q <= ld_addr_i;
    end
    // error response reads as zero
    if (bus.r_valid && bus.r_ready) begin
      data_q <= (bus.r_resp == RESP_OKAY) ? bus.r_data : '0;
    end
  end

  assign ld_busy_o = (state_q != L_IDLE);
  assign ld_done_o = done_q;
  assign ld_data_o = data_q;

endmodule

/* design/axi_rd_arbiter.sv */
`timescale 1ns/1ps

module axi_rd_arbiter (
  input  logic     clk,
  input  logic     rst_n,
  axi_rd_if.slave  m0,
  axi_rd_if.slave  m1,
  axi_rd_if.master s
);

  // lock_q marks a read outstanding on the shared bus
  logic lock_q;
  // 0 selects fetch and 1 selects load
  logic gnt_q;
  logic gnt;

  // the locked owner keeps the grant and load wins when idle
  assign gnt = lock_q ? gnt_q : m1.ar_valid;

  // no new address while a read is outstanding
  assign s.ar_valid = ~lock_q & (gnt ? m1.ar_valid : m0.ar_valid);
  assign s.ar_addr  = gnt ? m1.ar_addr : m0.ar_addr;
  assign m0.ar_ready = ~lock_q & ~gnt & s.ar_ready;
  assign m1.ar_ready = ~lock_q & gnt & s.ar_ready;

  // r routed only to the owner of the outstanding read
  assign s.r_ready  = lock_q & (gnt_q ? m1.r_ready : m0.r_ready);
  assign m0.r_valid = lock_q & ~gnt_q & s.r_valid;
  assign m1.r_valid = lock_q & gnt_q & s.r_valid;
  assign m0.r_data  = s.r_data;
  assign m1.r_data  = s.r_data;
  assign m0.r_resp  = s.r_resp;
  assign m1.r_resp  = s.r_resp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_q <= 1'b0;
      gnt_q  <= 1'b0;
    end else if (!lock_q && s.ar_valid && s.ar_ready) begin
      // lock at the ar transfer
      lock_q <= 1'b1;
      gnt_q  <= gnt;
    end else if (lock_q && s.r_valid && s.r_ready) begin
      // release at the r transfer
      lock_q <= 1'b0;
    end
  end

  // slave busy with a read only while the owner is locked
  a_gnt_held: assert property (@(posedge clk) disable iff (!rst_n)
    !s.ar_ready || s.r_valid |-> lock_q);

endmodule

/* design/axi_mem_slave.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module axi_mem_slave import fetch_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  axi_rd_if.slave          bus,
  input  logic             wr_en_i,
  input  logic [`XLEN-1:0] wr_addr_i,
  input  logic [`XLEN-1:0] wr_data_i
);

  localparam int AW = $clog2(`MEM_WORDS);
  localparam int CW = $clog2(`MEM_LATENCY + 1);

  logic [`XLEN-1:0] mem [`MEM_WORDS];
  logic             busy_q;
  logic [CW-1:0]    cnt_q;
  logic [`XLEN-1:0] data_q;
  axi_resp_e        resp_q;
  logic             ar_fire;
  logic             in_range;

  // accept only when idle
  assign bus.ar_ready = ~busy_q;
  assign ar_fire      = bus.ar_valid & ~busy_q;
  // upper address bits must be clear to hit the array
  assign in_range     = (bus.ar_addr[`XLEN-1:AW+2] == '0);

  // counter hits zero exactly MEM_LATENCY cycles after ar
  assign bus.r_valid = busy_q & (cnt_q == '0);
  assign bus.r_data  = data_q;
  assign bus.r_resp  = resp_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (ar_fire) begin
      busy_q <= 1'b1;
      cnt_q  <= CW'(`MEM_LATENCY - 1);
    end else if (bus.r_valid && bus.r_ready) begin
      busy_q <= 1'b0;
    end else if (busy_q && cnt_q != '0) begin
      cnt_q <= cnt_q - CW'(1);
    end
  end

  // preload port wraps on word index
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i[AW+1:2]] <= wr_data_i;
    end
  end

  // word sampled at ar and held until r is taken
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      data_q <= in_range ? mem[bus.ar_addr[AW+1:2]] : '0;
      resp_q <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_top import fetch_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_i,
  input  logic [`XLEN-1:0] redirect_pc_i,
  input  logic             stall_i,
  output logic             inst_valid_o,
  output logic [31:0]      inst_o,
  output logic [`XLEN-1:0] inst_pc_o,
  input  logic             ld_req_i,
  input  logic [`XLEN-1:0] ld_addr_i,
  output logic             ld_done_o,
  output logic [`XLEN-1:0] ld_data_o,
  output logic             ld_busy_o,
  input  logic             mem_wr_en_i,
  input  logic [`XLEN-1:0] mem_wr_addr_i,
  input  logic [`XLEN-1:0] mem_wr_data_i
);

  logic [`XLEN-1:0] fetch_pc;
  logic             rsp_strobe;
  inst_u            rsp_inst;

  // fetch, load and shared memory buses
  axi_rd_if if_bus ();
  axi_rd_if ld_bus ();
  axi_rd_if mem_bus ();

  pc_predict pc_predict_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .rsp_strobe_i  (rsp_strobe),
    .rsp_inst_i    (rsp_inst),
    .fetch_pc_o    (fetch_pc)
  );

  fetch_unit fetch_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_pc_i   (fetch_pc),
    .redirect_i   (redirect_i),
    .stall_i      (stall_i),
    .bus          (if_bus),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .rsp_strobe_o (rsp_strobe),
    .rsp_inst_o   (rsp_inst)
  );

  load_port load_port_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ld_req_i  (ld_req_i),
    .ld_addr_i (ld_addr_i),
    .bus       (ld_bus),
    .ld_done_o (ld_done_o),
    .ld_data_o (ld_data_o),
    .ld_busy_o (ld_busy_o)
  );

  // port 0 fetch, port 1 load
  axi_rd_arbiter axi_rd_arbiter_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .m0    (if_bus),
    .m1    (ld_bus),
    .s     (mem_bus)
  );

  axi_mem_slave axi_mem_slave_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (mem_bus),
    .wr_en_i   (mem_wr_en_i),
    .wr_addr_i (mem_wr_addr_i),
    .wr_data_i (mem_wr_data_i)
  );

endmodule

/* test/fetch_top_tb.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_top_tb;

  localparam int TRACE_WORDS = 256;
  localparam int TIMEOUT     = 200;

  // trace command codes
  localparam logic [31:0] CMD_END      = 32'h0;
  localparam logic [31:0] CMD_PRELOAD  = 32'h1;
  localparam logic [31:0] CMD_FETCH    = 32'h2;
  localparam logic [31:0] CMD_REDIRECT = 32'h3;
  localparam logic [31:0] CMD_STALL    = 32'h4;
  localparam logic [31:0] CMD_LOAD     = 32'h5;

  logic             clk;
  logic             rst_n;
  logic             redirect_i;
  logic [`XLEN-1:0] redirect_pc_i;
  logic             stall_i;
  logic             inst_valid_o;
  logic [31:0]      inst_o;
  logic [`XLEN-1:0] inst_pc_o;
  logic             ld_req_i;
  logic [`XLEN-1:0] ld_addr_i;
  logic             ld_done_o;
  logic [`XLEN-1:0] ld_data_o;
  logic             ld_busy_o;
  logic             mem_wr_en_i;
  logic [`XLEN-1:0] mem_wr_addr_i;
  logic [`XLEN-1:0] mem_wr_data_i;

  logic [31:0] trace [TRACE_WORDS];
  // expected load data in issue order
  logic [31:0] ld_expect_q [$];
  logic [31:0] ld_exp;
  logic [31:0] exp_pc;
  int          tp;
  int          tests;
  int          failed;
  bit          abort;
  bit          running;
  int          drain_cnt;

  fetch_top fetch_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .ld_req_i      (ld_req_i),
    .ld_addr_i     (ld_addr_i),
    .ld_done_o     (ld_done_o),
    .ld_data_o     (ld_data_o),
    .ld_busy_o     (ld_busy_o),
    .mem_wr_en_i   (mem_wr_en_i),
    .mem_wr_addr_i (mem_wr_addr_i),
    .mem_wr_data_i (mem_wr_data_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // static predictor straight from the isa immediate layout
  function automatic logic [31:0] predict_next(input logic [31:0] pc, input logic [31:0] w);
    logic [31:0] j_imm;
    logic [31:0] b_imm;
    j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    if (w[6:0] == `OPC_JAL) begin
      return pc + j_imm;
    end
    // only backward branches are taken
    if (w[6:0] == `OPC_BRANCH && w[31]) begin
      return pc + b_imm;
    end
    return pc + 32'd4;
  endfunction

  // step to just after the next rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s expected %08h got %08h", sig, exp, act);
  endtask

  task automatic finish_test(input string name, input bit ok);
    tests++;
    if (ok) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      failed++;
      $display("test %0d %s: fail", tests, name);
    end
  endtask

  task automatic write_mem(input logic [31:0] addr, input logic [31:0] data);
    mem_wr_en_i   = 1'b1;
    mem_wr_addr_i = addr;
    mem_wr_data_i = data;
    next_cycle();
    mem_wr_en_i   = 1'b0;
  endtask

  task automatic expect_fetch(input logic [31:0] word);
    int wait_cnt;
    bit ok;
    wait_cnt = 0;
    ok = 1'b1;
    while (!inst_valid_o && wait_cnt < TIMEOUT) begin
      next_cycle();
      wait_cnt++;
    end
    if (!inst_valid_o) begin
      $display("timeout: no instruction for pc %08h within %0d cycles", exp_pc, TIMEOUT);
      failed++;
      abort = 1'b1;
    end else begin
      if (inst_pc_o !== exp_pc) begin
        value_error("inst_pc_o", exp_pc, inst_pc_o);
        ok = 1'b0;
      end
      if (inst_o !== word) begin
        value_error("inst_o", word, inst_o);
        ok = 1'b0;
      end
      finish_test($sformatf("fetch pc %08h", exp_pc), ok);
      exp_pc = predict_next(exp_pc, word);
      // stall is low so this edge consumes it
      next_cycle();
    end
  endtask

  task automatic redirect_to(input logic [31:0] pc);
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    stall_i       = 1'b0;
    next_cycle();
    redirect_i    = 1'b0;
    exp_pc        = pc;
  endtask

  task automatic stall_for(input int n);
    logic [31:0] snap_inst;
    logic [31:0] snap_pc;
    bit          held;
    bit          ok;
    held = 1'b0;
    ok = 1'b1;
    stall_i = 1'b1;
    for (int i = 0; i < n; i++) begin
      next_cycle();
      if (inst_valid_o && !held) begin
        snap_inst = inst_o;
        snap_pc   = inst_pc_o;
        held      = 1'b1;
      end else if (held) begin
        if (!inst_valid_o) begin
          $display("inst_valid_o dropped while stalled");
          ok = 1'b0;
        end
        if (inst_o !== snap_inst) begin
          value_error("inst_o", snap_inst, inst_o);
          ok = 1'b0;
        end
        if (inst_pc_o !== snap_pc) begin
          value_error("inst_pc_o", snap_pc, inst_pc_o);
          ok = 1'b0;
        end
      end
    end
    if (!held) begin
      $display("no instruction arrived during the %0d-cycle stall", n);
      ok = 1'b0;
    end
    stall_i = 1'b0;
    finish_test($sformatf("stall %0d cycles", n), ok);
  endtask

  task automatic issue_load(input logic [31:0] addr, input logic [31:0] data);
    if (ld_busy_o) begin
      $display("load port still busy, load of %08h not issued", addr);
      finish_test($sformatf("load issue %08h", addr), 1'b0);
    end else begin
      ld_expect_q.push_back(data);
      ld_req_i  = 1'b1;
      ld_addr_i = addr;
      next_cycle();
      ld_req_i  = 1'b0;
      // accepted request keeps the port busy until done
      if (ld_busy_o !== 1'b1) begin
        value_error("ld_busy_o", 32'h1, {31'b0, ld_busy_o});
        finish_test($sformatf("load issue %08h", addr), 1'b0);
      end
    end
  endtask

  // load results checked on their own while fetch keeps running
  always @(negedge clk) begin
    if (rst_n && ld_done_o) begin
      if (ld_expect_q.size() == 0) begin
        $display("ld_done_o pulsed with no load outstanding");
        finish_test("load done", 1'b0);
      end else begin
        ld_exp = ld_expect_q.pop_front();
        if (ld_data_o !== ld_exp) begin
          value_error("ld_data_o", ld_exp, ld_data_o);
          finish_test("load data", 1'b0);
        end else begin
          finish_test($sformatf("load data %08h", ld_exp), 1'b1);
        end
      end
    end
  end

  initial begin
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    // fetch parked until the first redirect since memory is empty
    stall_i       = 1'b1;
    ld_req_i      = 1'b0;
    ld_addr_i     = '0;
    mem_wr_en_i   = 1'b0;
    mem_wr_addr_i = '0;
    mem_wr_data_i = '0;
    tests         = 0;
    failed        = 0;
    abort         = 1'b0;
    running       = 1'b1;
    tp            = 0;
    exp_pc        = `RESET_PC;
    $readmemh("test/fetch_trace.txt", trace);
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    while (running && !abort) begin
      if (tp > TRACE_WORDS - 3) begin
        $display("trace ran past its end without an end command");
        failed++;
        running = 1'b0;
      end else begin
        case (trace[tp])
          CMD_PRELOAD: begin
            write_mem(trace[tp+1], trace[tp+2]);
            tp += 3;
          end
          CMD_FETCH: begin
            expect_fetch(trace[tp+1]);
            tp += 2;
          end
          CMD_REDIRECT: begin
            redirect_to(trace[tp+1]);
            tp += 2;
          end
          CMD_STALL: begin
            stall_for(int'(trace[tp+1]));
            tp += 2;
          end
          CMD_LOAD: begin
            issue_load(trace[tp+1], trace[tp+2]);
            tp += 3;
          end
          CMD_END: begin
            running = 1'b0;
          end
          default: begin
            $display("unknown trace command %08h at word %0d", trace[tp], tp);
            failed++;
            running = 1'b0;
          end
        endcase
      end
    end

    // let outstanding loads come back
    drain_cnt = 0;
    while (ld_expect_q.size() != 0 && drain_cnt < TIMEOUT) begin
      next_cycle();
      drain_cnt++;
    end
    if (ld_expect_q.size() != 0) begin
      $display("timeout: %0d loads never completed", ld_expect_q.size());
      failed++;
    end

    $display("tests run %0d, failed %0d", tests, failed);
    if (failed == 0 && !abort) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* test/fetch_trace.txt */
// command word, then its operands, all hex
// 1 preload addr data, 2 fetch word, 3 redirect pc, 4 stall cycles, 5 load addr data, 0 end
1 00000000 00100093 // addi x1
1 00000004 00200113 // addi x2
1 00000008 00300193 // addi x3
1 0000000c 0140006f // jal +0x14
1 00000020 00000463 // beq forward
1 00000024 00400213 // addi x4
1 00000028 fe009ce3 // bne back to 0x20
1 00000040 00500293 // addi x5
1 00000044 00600313 // addi x6
1 00000048 00700393 // addi x7
1 0000004c ff5ff06f // jal back to 0x40
1 00000080 cafef00d // load data
3 00000000          // start at reset pc
2 00100093
2 00200113
2 00300193
2 0140006f
2 00000463
2 00400213
2 fe009ce3
2 00000463
4 0000000c          // hold 0x24 under stall
2 00400213
3 00000040          // 0x28 in flight, dropped
2 00500293
5 00000080 cafef00d
2 00600313
2 00700393
5 00001000 00000000 // out of range
2 ff5ff06f
2 00500293
5 00000044 00600313
2 00600313
0

/* fetch_top.f */
+incdir+design
design/fetch_pkg.sv
design/axi_rd_if.sv
design/pc_predict.sv
design/fetch_unit.sv
design/load_port.sv
design/axi_rd_arbiter.sv
design/axi_mem_slave.sv
design/fetch_top.sv
test/fetch_top_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fetch_top_tb
FILELIST   := fetch_top.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
